//--- all.f
logic/gateway_pkg.sv
logic/task_queue.sv
logic/reg_component.sv
logic/scratch_mem.sv
logic/host_reg_gateway.sv
logic/gateway_top.sv
verification/gateway_assert.sv
verification/gateway_tb.sv

//--- verification/gateway_tb.sv
module gateway_tb import gateway_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic       W      = 1'b1;
   localparam logic       R      = 1'b0;
   localparam logic [1:0] EXACT  = 2'd0;
   localparam logic [1:0] IGN    = 2'd1;
   localparam logic [1:0] GT     = 2'd2;   // Above the value read by the previous row
   localparam int         N_ROWS = 58;

   typedef struct packed {
      logic        write;
      logic [15:0] addr;
      logic [31:0] wdata;
      logic [31:0] expected;
      logic [1:0]  mode;
   } row_t;

   ////////////////////////////////////////
   // Test table
   ////////////////////////////////////////

   localparam row_t ROWS [N_ROWS] = '{
      '{W, 16'h0200, 32'ha0a0_0000, 32'd0, IGN},
      '{W, 16'h0201, 32'h1111_1111, 32'd0, IGN},
      '{W, 16'h0202, 32'h2222_2222, 32'd0, IGN},
      '{W, 16'h0203, 32'h3333_3333, 32'd0, IGN},
      '{R, 16'h0200, 32'd0, 32'ha0a0_0000, EXACT},
      '{R, 16'h0201, 32'd0, 32'h1111_1111, EXACT},
      '{R, 16'h0202, 32'd0, 32'h2222_2222, EXACT},
      '{R, 16'h0203, 32'd0, 32'h3333_3333, EXACT},
      '{R, {8'h01, REG_COMP_ID}, 32'd0, 32'd1, EXACT},
      '{R, {8'h02, REG_COMP_ID}, 32'd0, 32'd2, EXACT},
      '{R, {8'h03, REG_COMP_ID}, 32'd0, 32'd3, EXACT},
      '{R, 16'h0500, 32'd0, 32'd0, EXACT},               // No target 5
      // Broadcast to offset 1 of every component
      '{W, {ID_ALL, 8'h01}, 32'hbcbc_0001, 32'd0, IGN},
      '{R, 16'h0101, 32'd0, 32'hbcbc_0001, EXACT},
      '{R, 16'h0201, 32'd0, 32'hbcbc_0001, EXACT},
      '{R, 16'h0301, 32'd0, 32'hbcbc_0001, EXACT},
      '{R, 16'h0200, 32'd0, 32'ha0a0_0000, EXACT},
      '{W, {ID_GATEWAY, REG_TASK_LOCALE}, 32'h1000_0001, 32'd0, IGN},
      '{W, {ID_GATEWAY, REG_TASK_ARGS}, 32'h2000_0001, 32'd0, IGN},
      '{W, {ID_GATEWAY, REG_TASK_ENQ}, 32'h0000_0101, 32'd0, IGN},
      '{W, {ID_GATEWAY, REG_TASK_LOCALE}, 32'h1000_0002, 32'd0, IGN},
      '{W, {ID_GATEWAY, REG_TASK_ARGS}, 32'h2000_0002, 32'd0, IGN},
      '{W, {ID_GATEWAY, REG_TASK_ENQ}, 32'h0000_0202, 32'd0, IGN},
      '{W, {ID_GATEWAY, REG_TASK_LOCALE}, 32'h1000_0003, 32'd0, IGN},
      '{W, {ID_GATEWAY, REG_TASK_ARGS}, 32'h2000_0003, 32'd0, IGN},
      '{W, {ID_GATEWAY, REG_TASK_ENQ}, 32'h0000_0303, 32'd0, IGN},
      '{R, {ID_GATEWAY, REG_QUEUE_COUNT}, 32'd0, 32'd3, EXACT},
      '{R, {ID_GATEWAY, REG_TASK_ENQ}, 32'd0, 32'h0000_0101, EXACT},
      '{R, {ID_GATEWAY, REG_TASK_LOCALE}, 32'd0, 32'h1000_0001, EXACT},
      '{R, {ID_GATEWAY, REG_TASK_ARGS}, 32'd0, 32'h2000_0001, EXACT},
      '{R, {ID_GATEWAY, REG_TASK_ENQ}, 32'd0, 32'h0000_0202, EXACT},
      '{R, {ID_GATEWAY, REG_TASK_LOCALE}, 32'd0, 32'h1000_0002, EXACT},
      '{R, {ID_GATEWAY, REG_TASK_ARGS}, 32'd0, 32'h2000_0002, EXACT},
      '{R, {ID_GATEWAY, REG_TASK_ENQ}, 32'd0, 32'h0000_0303, EXACT},
      '{R, {ID_GATEWAY, REG_TASK_LOCALE}, 32'd0, 32'h1000_0003, EXACT},
      '{R, {ID_GATEWAY, REG_TASK_ARGS}, 32'd0, 32'h2000_0003, EXACT},
      '{R, {ID_GATEWAY, REG_TASK_ENQ}, 32'd0, TASK_EMPTY_TS, EXACT},
      // Scratch memory accesses, each followed by a latency read
      '{W, {ID_GATEWAY, REG_MEM_ADDR}, 32'h0000_0012, 32'd0, IGN},
      '{W, {ID_GATEWAY, REG_MEM_ACCESS}, 32'hdead_0012, 32'd0, IGN},
      '{R, {ID_GATEWAY, REG_LAST_MEM_LATENCY}, 32'd0, 32'd5, EXACT},
      '{W, {ID_GATEWAY, REG_MEM_ADDR}, 32'h0000_0034, 32'd0, IGN},
      '{W, {ID_GATEWAY, REG_MEM_ACCESS}, 32'hcafe_0034, 32'd0, IGN},
      '{R, {ID_GATEWAY, REG_LAST_MEM_LATENCY}, 32'd0, 32'd5, EXACT},
      '{W, {ID_GATEWAY, REG_MEM_ADDR}, 32'h0000_0012, 32'd0, IGN},
      '{R, {ID_GATEWAY, REG_MEM_ACCESS}, 32'd0, 32'hdead_0012, EXACT},
      '{R, {ID_GATEWAY, REG_LAST_MEM_LATENCY}, 32'd0, 32'd5, EXACT},
      '{W, {ID_GATEWAY, REG_MEM_ADDR}, 32'h0000_0034, 32'd0, IGN},
      '{R, {ID_GATEWAY, REG_MEM_ACCESS}, 32'd0, 32'hcafe_0034, EXACT},
      '{R, {ID_GATEWAY, REG_LAST_MEM_LATENCY}, 32'd0, 32'd5, EXACT},
      '{W, {ID_GATEWAY, REG_MEM_ADDR}, 32'h0000_0077, 32'd0, IGN},
      '{R, {ID_GATEWAY, REG_MEM_ACCESS}, 32'd0, 32'd0, EXACT},
      '{R, {ID_GATEWAY, REG_LAST_MEM_LATENCY}, 32'd0, 32'd5, EXACT},
      '{R, {ID_GATEWAY, REG_PARAM_N_COMP}, 32'd0, 32'd3, EXACT},
      '{R, {ID_GATEWAY, REG_PARAM_TQ_DEPTH}, 32'd0, 32'd4, EXACT},
      '{R, {ID_GATEWAY, REG_PARAM_MEM_LATENCY}, 32'd0, 32'd5, EXACT},
      '{R, {ID_GATEWAY, REG_CUR_CYCLE_LSB}, 32'd0, 32'd0, IGN},
      '{R, {ID_GATEWAY, REG_CUR_CYCLE_LSB}, 32'd0, 32'd0, GT},
      '{R, {ID_GATEWAY, REG_CUR_CYCLE_MSB}, 32'd0, 32'd0, EXACT}
   };

   logic      clk       = 1'b0;
   logic      rstn      = 1'b0;
   host_req_t req       = '0;
   logic      req_valid = 1'b0;
   logic      req_ready;
   host_rsp_t rsp;
   logic      rsp_valid;
   logic      rsp_ready = 1'b0;

   always #20 clk = ~clk;

   gateway_top dut (
      .clk(clk), .rstn(rstn), .req(req), .req_valid(req_valid), .req_ready(req_ready),
      .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready)
   );

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   // One request and its response, with a random stall before the response is taken
   task automatic run_transfer(input row_t row, input logic has_next, input row_t next_row,
                               output logic [31:0] data);
      int unsigned hold;
      req       <= '{row.write, row.addr, row.wdata};
      req_valid <= 1'b1;
      rsp_ready <= 1'b0;
      do begin
         @(posedge clk);
      end while (!req_ready);
      req_valid <= 1'b0;
      do begin
         @(posedge clk);
      end while (!rsp_valid);
      if (has_next) begin
         req       <= '{next_row.write, next_row.addr, next_row.wdata};
         req_valid <= 1'b1;   // Next request waits behind the stalled response
      end
      hold = $urandom_range(3, 0);
      repeat (hold) @(posedge clk);
      rsp_ready <= 1'b1;
      do begin
         @(posedge clk);
      end while (!rsp_valid);
      data = rsp.rdata;
      rsp_ready <= 1'b0;
   endtask

   task automatic check_value(input int row, input logic [15:0] addr, input logic [1:0] mode,
                              input logic [31:0] actual, input logic [31:0] reference);
      logic  ok;
      string rel;
      case (mode)
         EXACT:   ok = (actual === reference);
         GT:      ok = ((actual > reference) === 1'b1);
         default: ok = 1'b1;
      endcase
      rel = (mode == GT) ? "above " : "";
      if (!ok) begin
         $display("[FAIL] %0d ns: row %0d address %h read %h, expected %s%h",
                  $time, row, addr, actual, rel, reference);
         $display(">>> FAIL");
         $fatal(1, "Check failed at row %0d", row);
      end
   endtask

   ////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////

   initial begin : main_seq
      logic [31:0] data;
      logic [31:0] prev_data;
      void'($urandom(42));
      prev_data = '0;
      repeat (10) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < N_ROWS; i++) begin
         run_transfer(ROWS[i], (i + 1 < N_ROWS), ROWS[(i + 1) % N_ROWS], data);
         check_value(i, ROWS[i].addr, ROWS[i].mode, data,
                     (ROWS[i].mode == GT) ? prev_data : ROWS[i].expected);
         prev_data = data;
      end
      $display(">>> PASS");
      $finish;
   end

   initial begin : watchdog
      #(N_ROWS * 100 * 40);
      $display("Timeout: the test table did not finish within %0d cycles", N_ROWS * 100);
      $display(">>> FAIL");
      $fatal(1, "Watchdog expired");
   end

endmodule

//--- verification/gateway_assert.sv
module gateway_assert import gateway_pkg::*; #(
   parameter int N_COMP = 3
) (
   input logic              clk,
   input logic              rstn,
   input host_req_t         req,
   input logic              req_valid,
   input logic              req_ready,
   input host_rsp_t         rsp,
   input logic              rsp_valid,
   input logic              rsp_ready,
   input logic [N_COMP-1:0] reg_arvalid
);
   timeunit 1ns;
   timeprecision 100ps;

   ////////////////////////////////////////
   // Host handshakes
   ////////////////////////////////////////

   property p_req_hold;
      @(posedge clk) disable iff (!rstn)
         (req_valid && !req_ready) |=> (req_valid && $stable(req));
   endproperty

   property p_rsp_hold;
      @(posedge clk) disable iff (!rstn)
         (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp));
   endproperty

   a_req_hold: assert property (p_req_hold)
      else $error("Host request changed while waiting for req_ready");

   a_rsp_hold: assert property (p_rsp_hold)
      else $error("Host response changed while waiting for rsp_ready");

   // Only one component may be read at a time
   a_arvalid_single: assert property (@(posedge clk) disable iff (!rstn) $onehot0(reg_arvalid))
      else $error("More than one reg_arvalid bit raised");

endmodule

bind host_reg_gateway gateway_assert #(.N_COMP(N_COMP)) u_assert (
   .clk(clk), .rstn(rstn), .req(req), .req_valid(req_valid), .req_ready(req_ready),
   .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .reg_arvalid(reg_arvalid)
);

//--- logic/gateway_top.sv
module gateway_top import gateway_pkg::*; #(
   parameter int N_COMP      = 3,
   parameter int TQ_DEPTH    = 4,
   parameter int MEM_LATENCY = 5
) (
   input  logic      clk,
   input  logic      rstn,
   input  host_req_t req,
   input  logic      req_valid,
   output logic      req_ready,
   output host_rsp_t rsp,
   output logic      rsp_valid,
   input  logic      rsp_ready
);

   reg_wr_t                       reg_wr;
   logic [N_COMP-1:0]             reg_wvalid;
   logic [7:0]                    reg_araddr;
   logic [N_COMP-1:0]             reg_arvalid;
   logic [N_COMP-1:0]             reg_rvalid;
   logic [N_COMP-1:0][31:0]       reg_rdata;
   logic                          task_push;
   task_t                         task_in;
   logic                          task_push_ready;
   logic                          task_pop;
   task_t                         task_out;
   logic [$clog2(TQ_DEPTH+1)-1:0] task_count;
   logic                          task_empty;
   mem_req_t                      mem_req;
   logic                          mem_req_valid;
   logic                          mem_req_ready;
   logic                          mem_rsp_valid;
   logic [31:0]                   mem_rdata;

   host_reg_gateway #(
      .N_COMP(N_COMP), .TQ_DEPTH(TQ_DEPTH), .MEM_LATENCY(MEM_LATENCY)
   ) u_gateway (.*);

   task_queue #(.TQ_DEPTH(TQ_DEPTH)) u_task_queue (.*);

   scratch_mem #(.MEM_LATENCY(MEM_LATENCY)) u_scratch_mem (.*);

   // Bus target k+1 answers on vector bit k
   for (genvar k = 0; k < N_COMP; k++) begin : g_comp
      reg_component #(.COMP_ID(k + 1)) u_comp (
         .clk(clk), .rstn(rstn), .reg_wr(reg_wr),
         .wvalid(reg_wvalid[k]), .araddr(reg_araddr), .arvalid(reg_arvalid[k]),
         .rvalid(reg_rvalid[k]), .rdata(reg_rdata[k])
      );
   end

endmodule

//--- logic/host_reg_gateway.sv
module host_reg_gateway import gateway_pkg::*; #(
   parameter int N_COMP      = 3,
   parameter int TQ_DEPTH    = 4,
   parameter int MEM_LATENCY = 5
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  host_req_t                     req,
   input  logic                          req_valid,
   output logic                          req_ready,
   output host_rsp_t                     rsp,
   output logic                          rsp_valid,
   input  logic                          rsp_ready,
   output reg_wr_t                       reg_wr,
   output logic [N_COMP-1:0]             reg_wvalid,
   output logic [7:0]                    reg_araddr,
   output logic [N_COMP-1:0]             reg_arvalid,
   input  logic [N_COMP-1:0]             reg_rvalid,
   input  logic [N_COMP-1:0][31:0]       reg_rdata,
   output logic                          task_push,
   output task_t                         task_in,
   input  logic                          task_push_ready,
   output logic                          task_pop,
   input  task_t                         task_out,
   input  logic [$clog2(TQ_DEPTH+1)-1:0] task_count,
   input  logic                          task_empty,
   output mem_req_t                      mem_req,
   output logic                          mem_req_valid,
   input  logic                          mem_req_ready,
   input  logic                          mem_rsp_valid,
   input  logic [31:0]                   mem_rdata
);

   typedef enum logic [2:0] {ST_IDLE, ST_EXEC, ST_WAIT_COMP, ST_WAIT_MEM, ST_RESP} state_t;

   state_t            state;
   host_req_t         req_q;
   logic [31:0]       rsp_data;
   logic [63:0]       cur_cycle;
   logic [31:0]       lat_start;
   logic [31:0]       last_mem_latency;
   logic [31:0]       task_locale;
   logic [29:0]       task_args;
   logic [1:0]        task_ttype;
   logic [15:0]       mem_addr;
   logic [7:0]        tgt;
   logic [7:0]        offs;
   logic              local_hit;
   logic              comp_hit;
   logic              is_enq;
   logic              is_mem;
   logic              exec;
   logic [N_COMP-1:0] comp_sel;
   logic [31:0]       comp_rdata;
   logic [31:0]       local_rdata;

   ////////////////////////////////////////
   // Decode of the captured request
   ////////////////////////////////////////

   assign tgt       = req_q.addr[15:8];
   assign offs      = req_q.addr[7:0];
   assign local_hit = (tgt == ID_GATEWAY);
   assign is_enq    = local_hit && (offs == REG_TASK_ENQ);
   assign is_mem    = local_hit && (offs == REG_MEM_ACCESS);
   assign exec      = (state == ST_EXEC);

   // Target k+1 sits on bit k, so ID_ALL and the gateway never hit here
   always_comb begin
      comp_rdata = '0;
      for (int k = 0; k < N_COMP; k++) begin
         comp_sel[k] = (tgt == 8'(k + 1));
         if (comp_sel[k]) comp_rdata = reg_rdata[k];
      end
   end
   assign comp_hit = |comp_sel;

   always_comb begin
      case (offs)
         REG_TASK_LOCALE:       local_rdata = task_locale;
         REG_TASK_ARGS:         local_rdata = {2'b00, task_args};
         REG_TASK_TTYPE:        local_rdata = {30'd0, task_ttype};
         REG_MEM_ADDR:          local_rdata = {16'd0, mem_addr};
         REG_CUR_CYCLE_LSB:     local_rdata = cur_cycle[31:0];
         REG_CUR_CYCLE_MSB:     local_rdata = cur_cycle[63:32];
         REG_LAST_MEM_LATENCY:  local_rdata = last_mem_latency;
         REG_QUEUE_COUNT:       local_rdata = 32'(task_count);
         REG_PARAM_N_COMP:      local_rdata = 32'(N_COMP);
         REG_PARAM_TQ_DEPTH:    local_rdata = 32'(TQ_DEPTH);
         REG_PARAM_MEM_LATENCY: local_rdata = 32'(MEM_LATENCY);
         default:               local_rdata = '0;
      endcase
   end

   ////////////////////////////////////////
   // Sequencer
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state     <= ST_IDLE;
         cur_cycle <= '0;
      end else begin
         cur_cycle <= cur_cycle + 64'd1;
         case (state)
            ST_IDLE: if (req_valid) state <= ST_EXEC;
            ST_EXEC: begin
               if (is_enq && req_q.write) begin
                  if (task_push_ready) state <= ST_RESP;   // Full queue holds the enqueue
               end else if (is_mem) begin
                  if (mem_req_ready) state <= ST_WAIT_MEM;
               end else if (comp_hit && !req_q.write) begin
                  state <= ST_WAIT_COMP;
               end else begin
                  state <= ST_RESP;
               end
            end
            ST_WAIT_COMP: if (|(reg_rvalid & comp_sel)) state <= ST_RESP;
            ST_WAIT_MEM:  if (mem_rsp_valid) state <= ST_RESP;
            ST_RESP:      if (rsp_ready) state <= ST_IDLE;
            default:      state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) req_q <= req;
      case (state)
         ST_EXEC: begin
            if (req_q.write) begin
               rsp_data <= '0;
               if (local_hit) begin
                  case (offs)
                     REG_TASK_LOCALE: task_locale <= req_q.wdata;
                     REG_TASK_ARGS:   task_args   <= req_q.wdata[29:0];
                     REG_TASK_TTYPE:  task_ttype  <= req_q.wdata[1:0];
                     REG_MEM_ADDR:    mem_addr    <= req_q.wdata[15:0];
                     default: ;
                  endcase
               end
            end else if (is_enq) begin
               if (task_empty) begin
                  rsp_data <= TASK_EMPTY_TS;
               end else begin
                  rsp_data    <= task_out.ts;
                  task_locale <= task_out.locale;   // Later field reads see the popped task
                  task_args   <= task_out.args;
               end
            end else begin
               rsp_data <= local_hit ? local_rdata : '0;
            end
            if (mem_req_valid && mem_req_ready) lat_start <= cur_cycle[31:0];
         end
         ST_WAIT_COMP: if (|(reg_rvalid & comp_sel)) rsp_data <= comp_rdata;
         ST_WAIT_MEM: begin
            if (mem_rsp_valid) begin
               last_mem_latency <= cur_cycle[31:0] - lat_start;
               if (!req_q.write) rsp_data <= mem_rdata;
            end
         end
         default: ;
      endcase
   end

   assign req_ready = (state == ST_IDLE);
   assign rsp_valid = (state == ST_RESP);
   assign rsp.rdata = rsp_data;

   // Broadcast raises every component at once
   assign reg_wvalid  = (exec && req_q.write) ? ((tgt == ID_ALL) ? '1 : comp_sel) : '0;
   assign reg_arvalid = (exec && !req_q.write) ? comp_sel : '0;
   assign reg_wr.addr = offs;
   assign reg_wr.data = req_q.wdata;
   assign reg_araddr  = offs;

   assign task_push      = exec && req_q.write && is_enq;
   assign task_pop       = exec && !req_q.write && is_enq && !task_empty;
   assign task_in.ts     = req_q.wdata;
   assign task_in.locale = task_locale;
   assign task_in.args   = task_args;
   assign task_in.ttype  = task_ttype;

   assign mem_req_valid = exec && is_mem;
   assign mem_req.write = req_q.write;
   assign mem_req.addr  = mem_addr;
   assign mem_req.wdata = req_q.wdata;

endmodule

//--- logic/scratch_mem.sv
module scratch_mem import gateway_pkg::*; #(
   parameter int MEM_LATENCY = 5,
   parameter int DEPTH       = 256
) (
   input  logic        clk,
   input  logic        rstn,
   input  mem_req_t    mem_req,
   input  logic        mem_req_valid,
   output logic        mem_req_ready,
   output logic        mem_rsp_valid,
   output logic [31:0] mem_rdata
);

   localparam int AW = $clog2(DEPTH);
   localparam int LW = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

   logic [31:0]    mem [DEPTH];
   logic [DEPTH-1:0] written;   // Marks words stored since reset
   logic           busy;
   logic [LW-1:0]  cnt;
   logic [AW-1:0]  waddr;
   logic           accept;
   logic [31:0]    rdata_q;

   assign waddr         = mem_req.addr[AW-1:0];
   assign accept        = mem_req_valid && mem_req_ready;
   assign mem_req_ready = !busy;
   assign mem_rsp_valid = busy && (cnt == '0);
   assign mem_rdata     = rdata_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy    <= 1'b0;
         cnt     <= '0;
         written <= '0;
      end else begin
         if (accept) begin
            busy <= 1'b1;
            cnt  <= LW'(MEM_LATENCY - 1);   // Response lands MEM_LATENCY cycles after accept
            if (mem_req.write) written[waddr] <= 1'b1;
         end else if (busy) begin
            if (cnt == '0) begin
               busy <= 1'b0;
            end else begin
               cnt <= cnt - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         if (mem_req.write) begin
            mem[waddr] <= mem_req.wdata;
            rdata_q    <= '0;
         end else begin
            rdata_q <= written[waddr] ? mem[waddr] : '0;
         end
      end
   end

endmodule

//--- logic/reg_component.sv
module reg_component import gateway_pkg::*; #(
   parameter int COMP_ID = 1
) (
   input  logic        clk,
   input  logic        rstn,
   input  reg_wr_t     reg_wr,
   input  logic        wvalid,
   input  logic [7:0]  araddr,
   input  logic        arvalid,
   output logic        rvalid,
   output logic [31:0] rdata
);

   logic [31:0] data_regs [4];
   logic [31:0] lookup;
   logic        rv_s1;
   logic [31:0] rd_s1;

   always_ff @(posedge clk) begin
      if (wvalid && (reg_wr.addr < 8'd4)) data_regs[reg_wr.addr[1:0]] <= reg_wr.data;
   end

   always_comb begin
      if (araddr < 8'd4) begin
         lookup = data_regs[araddr[1:0]];
      end else if (araddr == REG_COMP_ID) begin
         lookup = 32'(COMP_ID);
      end else begin
         lookup = '0;
      end
   end

   // Two register stages give the fixed read latency
   always_ff @(posedge clk) begin
      if (!rstn) begin
         rv_s1  <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         rv_s1  <= arvalid;
         rvalid <= rv_s1;
      end
   end

   always_ff @(posedge clk) begin
      rd_s1 <= lookup;
      rdata <= rd_s1;
   end

endmodule

//--- logic/task_queue.sv
module task_queue import gateway_pkg::*; #(
   parameter int TQ_DEPTH = 4
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          task_push,
   input  task_t                         task_in,
   output logic                          task_push_ready,
   input  logic                          task_pop,
   output task_t                         task_out,
   output logic [$clog2(TQ_DEPTH+1)-1:0] task_count,
   output logic                          task_empty
);

   localparam int PW = (TQ_DEPTH > 1) ? $clog2(TQ_DEPTH) : 1;
   localparam int CW = $clog2(TQ_DEPTH + 1);

   task_t         entries [TQ_DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          push_en;
   logic          pop_en;

   assign push_en = task_push && task_push_ready;
   assign pop_en  = task_pop && !task_empty;

   always_ff @(posedge clk) begin
      if (push_en) entries[wr_ptr] <= task_in;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_en) wr_ptr <= (wr_ptr == PW'(TQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop_en) rd_ptr <= (rd_ptr == PW'(TQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push_en, pop_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;   // Push and pop together leave the count unchanged
         endcase
      end
   end

   assign task_push_ready = (count != CW'(TQ_DEPTH));
   assign task_empty      = (count == '0);
   assign task_count      = count;
   assign task_out        = entries[rd_ptr];

endmodule

//--- logic/gateway_pkg.sv
package gateway_pkg;

   ////////////////////////////////////////
   // Bus payloads
   ////////////////////////////////////////

   typedef struct packed {
      logic        write;
      logic [15:0] addr;    // Target in [15:8], register in [7:0]
      logic [31:0] wdata;
   } host_req_t;

   typedef struct packed {
      logic [31:0] rdata;
   } host_rsp_t;

   typedef struct packed {
      logic [31:0] ts;
      logic [31:0] locale;
      logic [29:0] args;
      logic [1:0]  ttype;
   } task_t;

   typedef struct packed {
      logic [7:0]  addr;
      logic [31:0] data;
   } reg_wr_t;

   typedef struct packed {
      logic        write;
      logic [15:0] addr;    // Word address
      logic [31:0] wdata;
   } mem_req_t;

   ////////////////////////////////////////
   // Register map
   ////////////////////////////////////////

   localparam logic [7:0] REG_TASK_ENQ          = 8'h00;
   localparam logic [7:0] REG_TASK_LOCALE       = 8'h04;
   localparam logic [7:0] REG_TASK_ARGS         = 8'h08;
   localparam logic [7:0] REG_TASK_TTYPE        = 8'h0c;
   localparam logic [7:0] REG_MEM_ADDR          = 8'h10;
   localparam logic [7:0] REG_MEM_ACCESS        = 8'h14;
   localparam logic [7:0] REG_CUR_CYCLE_LSB     = 8'h20;
   localparam logic [7:0] REG_CUR_CYCLE_MSB     = 8'h24;
   localparam logic [7:0] REG_LAST_MEM_LATENCY  = 8'h28;
   localparam logic [7:0] REG_QUEUE_COUNT       = 8'h2c;
   localparam logic [7:0] REG_PARAM_N_COMP      = 8'h30;
   localparam logic [7:0] REG_PARAM_TQ_DEPTH    = 8'h34;
   localparam logic [7:0] REG_PARAM_MEM_LATENCY = 8'h38;

   localparam logic [7:0] ID_GATEWAY = 8'h00;
   localparam logic [7:0] ID_ALL     = 8'hff;

   localparam logic [7:0] REG_COMP_ID = 8'h10;   // Identity register of a component

   localparam logic [31:0] TASK_EMPTY_TS = 32'hffff_ffff;

endpackage
